//--- logic/weight_read_pkg.sv
package weight_read_pkg;

   // external bus widths
   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;

   // 64-word on-chip weight buffer
   localparam int BUF_ADDR_W = 6;

   // length, iteration and period counts
   localparam int CNT_W = 8;

   // cpu register index
   localparam int CFG_ADDR_W = 3;

   typedef logic [ADDR_W-1:0]     addr_t;
   typedef logic [DATA_W-1:0]     data_t;
   typedef logic [BUF_ADDR_W-1:0] buf_addr_t;
   typedef logic [CNT_W-1:0]      cnt_t;
   typedef logic [CFG_ADDR_W-1:0] cfg_addr_t;

   // fetch setup
   localparam cfg_addr_t CFG_EXT_ADDR = 3'd0;
   localparam cfg_addr_t CFG_LEN      = 3'd1;
   localparam cfg_addr_t CFG_INT_ADDR = 3'd2;

   // stream read pattern
   localparam cfg_addr_t CFG_ITER     = 3'd3;
   localparam cfg_addr_t CFG_PER      = 3'd4;
   localparam cfg_addr_t CFG_START    = 3'd5;
   localparam cfg_addr_t CFG_SHIFT    = 3'd6;
   localparam cfg_addr_t CFG_INCR     = 3'd7;

endpackage

//--- logic/read_config.sv
module read_config import weight_read_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      cfg_valid,
   input  logic      cfg_we,
   input  cfg_addr_t cfg_addr,
   input  data_t     cfg_wdata,
   input  logic      run,
   output addr_t     ext_addr,
   output cnt_t      len,
   output buf_addr_t int_addr,
   output cnt_t      iter,
   output cnt_t      per,
   output buf_addr_t start,
   output buf_addr_t shift,
   output buf_addr_t incr
);

   // working copies, written by the cpu at any time
   addr_t     ext_addr_w;
   cnt_t      len_w;
   buf_addr_t int_addr_w;
   cnt_t      iter_w;
   cnt_t      per_w;
   buf_addr_t start_w;
   buf_addr_t shift_w;
   buf_addr_t incr_w;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ext_addr_w <= '0;
         len_w      <= '0;
         int_addr_w <= '0;
         iter_w     <= '0;
         per_w      <= '0;
         start_w    <= '0;
         shift_w    <= '0;
         incr_w     <= '0;
      end else if (cfg_valid && cfg_we) begin
         case (cfg_addr)
            CFG_EXT_ADDR: ext_addr_w <= cfg_wdata[ADDR_W-1:0];
            CFG_LEN:      len_w      <= cfg_wdata[CNT_W-1:0];
            CFG_INT_ADDR: int_addr_w <= cfg_wdata[BUF_ADDR_W-1:0];
            CFG_ITER:     iter_w     <= cfg_wdata[CNT_W-1:0];
            CFG_PER:      per_w      <= cfg_wdata[CNT_W-1:0];
            CFG_START:    start_w    <= cfg_wdata[BUF_ADDR_W-1:0];
            CFG_SHIFT:    shift_w    <= cfg_wdata[BUF_ADDR_W-1:0];
            default:      incr_w     <= cfg_wdata[BUF_ADDR_W-1:0];
         endcase
      end
   end

   // shadow set, frozen for the whole run
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ext_addr <= '0;
         len      <= '0;
         int_addr <= '0;
         iter     <= '0;
         per      <= '0;
         start    <= '0;
         shift    <= '0;
         incr     <= '0;
      end else if (run) begin
         ext_addr <= ext_addr_w;
         len      <= len_w;
         int_addr <= int_addr_w;
         iter     <= iter_w;
         per      <= per_w;
         start    <= start_w;
         shift    <= shift_w;
         incr     <= incr_w;
      end
   end

endmodule

//--- logic/weight_fetch.sv
module weight_fetch import weight_read_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      run,
   input  addr_t     ext_addr,
   input  cnt_t      len,
   input  buf_addr_t int_addr,
   input  logic      wb_ack,
   input  data_t     wb_dat_i,
   output logic      wb_cyc,
   output logic      wb_stb,
   output addr_t     wb_adr,
   output logic      wr_en,
   output buf_addr_t wr_addr,
   output data_t     wr_data,
   output logic      fetch_done
);

   typedef enum logic {
      IDLE,
      BUSY
   } state_t;

   state_t state;

   // index of the transfer in progress
   cnt_t xfer_cnt;

   logic last_seen;
   logic xfer_open;

   // shadow values become valid one cycle after run,
   // so the length compare is done from the busy state
   assign last_seen = (state == BUSY) && (xfer_cnt == len);
   assign xfer_open = (state == BUSY) && (xfer_cnt != len);

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         state    <= IDLE;
         xfer_cnt <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (run) begin
                  state    <= BUSY;
                  xfer_cnt <= '0;
               end
            end
            default: begin
               if (last_seen) begin
                  state <= IDLE;
               end else if (wb_ack) begin
                  xfer_cnt <= xfer_cnt + 1'b1;
               end
            end
         endcase
      end
   end

   // classic cycle held until the slave acks
   assign wb_cyc = xfer_open;
   assign wb_stb = xfer_open;
   assign wb_adr = ext_addr + addr_t'(xfer_cnt);

   // acked word goes straight into the buffer
   assign wr_en   = xfer_open && wb_ack;
   assign wr_addr = int_addr + xfer_cnt[BUF_ADDR_W-1:0];
   assign wr_data = wb_dat_i;

   // high one cycle after the last ack, or right after run for len zero
   assign fetch_done = last_seen;

endmodule

//--- logic/weight_buffer.sv
module weight_buffer import weight_read_pkg::*; (
   input  logic      clk,
   input  logic      wr_en,
   input  buf_addr_t wr_addr,
   input  data_t     wr_data,
   input  logic      rd_en,
   input  buf_addr_t rd_addr,
   output data_t     rd_data
);

   localparam int DEPTH = 2 ** BUF_ADDR_W;

   data_t mem [0:DEPTH-1];

   // write port, fed by the fetch engine
   always_ff @(posedge clk) begin
      if (wr_en) begin
         mem[wr_addr] <= wr_data;
      end
   end

   // registered read port, one cycle latency
   always_ff @(posedge clk) begin
      if (rd_en) begin
         rd_data <= mem[rd_addr];
      end
   end

endmodule

//--- logic/weight_stream.sv
module weight_stream import weight_read_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      fetch_done,
   input  cnt_t      iter,
   input  cnt_t      per,
   input  buf_addr_t start,
   input  buf_addr_t shift,
   input  buf_addr_t incr,
   input  data_t     rd_data,
   output logic      rd_en,
   output buf_addr_t rd_addr,
   output data_t     weight_out,
   output logic      weight_valid,
   output logic      busy
);

   logic      gen_active;
   cnt_t      iter_cnt;
   cnt_t      per_cnt;
   buf_addr_t row_base;
   buf_addr_t addr;
   logic      rd_valid;
   logic      per_last;
   logic      iter_last;

   assign per_last  = (per_cnt == per - 1'b1);
   assign iter_last = (iter_cnt == iter - 1'b1);

   // nested loop address generator, one read per cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         gen_active <= 1'b0;
         iter_cnt   <= '0;
         per_cnt    <= '0;
         row_base   <= '0;
         addr       <= '0;
      end else if (fetch_done) begin
         // empty pattern when either count is zero
         gen_active <= (iter != '0) && (per != '0);
         iter_cnt   <= '0;
         per_cnt    <= '0;
         row_base   <= start;
         addr       <= start;
      end else if (gen_active) begin
         if (per_last) begin
            per_cnt  <= '0;
            row_base <= row_base + shift;
            addr     <= row_base + shift;
            if (iter_last) begin
               gen_active <= 1'b0;
            end else begin
               iter_cnt <= iter_cnt + 1'b1;
            end
         end else begin
            per_cnt <= per_cnt + 1'b1;
            addr    <= addr + incr;
         end
      end
   end

   assign rd_en   = gen_active;
   assign rd_addr = addr;

   // two stage valid pipe, buffer read then output register
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         rd_valid     <= 1'b0;
         weight_valid <= 1'b0;
      end else begin
         rd_valid     <= rd_en;
         weight_valid <= rd_valid;
      end
   end

   always_ff @(posedge clk) begin
      if (rd_valid) begin
         weight_out <= rd_data;
      end
   end

   // drops on the cycle after the last valid weight
   assign busy = gen_active || rd_valid || weight_valid;

endmodule

//--- logic/weight_read_top.sv
module weight_read_top import weight_read_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      cfg_valid,
   input  logic      cfg_we,
   input  cfg_addr_t cfg_addr,
   input  data_t     cfg_wdata,
   input  logic      run,
   input  logic      wb_ack,
   input  data_t     wb_dat_i,
   output logic      done,
   output logic      wb_cyc,
   output logic      wb_stb,
   output addr_t     wb_adr,
   output data_t     weight_out,
   output logic      weight_valid
);

   addr_t     ext_addr;
   cnt_t      len;
   buf_addr_t int_addr;
   cnt_t      iter;
   cnt_t      per;
   buf_addr_t start;
   buf_addr_t shift;
   buf_addr_t incr;
   logic      wr_en;
   buf_addr_t wr_addr;
   data_t     wr_data;
   logic      fetch_done;
   logic      rd_en;
   buf_addr_t rd_addr;
   data_t     rd_data;
   logic      stream_busy;
   logic      fetch_phase;
   logic      run_ok;

   // run only taken when idle
   assign run_ok = run && done;

   // fetch phase runs from an accepted run up to fetch_done
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         fetch_phase <= 1'b0;
      end else if (run_ok) begin
         fetch_phase <= 1'b1;
      end else if (fetch_done) begin
         fetch_phase <= 1'b0;
      end
   end

   assign done = !(fetch_phase || stream_busy);

   read_config read_config_inst (
      .clk, .rst, .cfg_valid, .cfg_we, .cfg_addr, .cfg_wdata, .run(run_ok),
      .ext_addr, .len, .int_addr, .iter, .per, .start, .shift, .incr
   );

   weight_fetch weight_fetch_inst (
      .clk, .rst, .run(run_ok), .ext_addr, .len, .int_addr, .wb_ack, .wb_dat_i,
      .wb_cyc, .wb_stb, .wb_adr, .wr_en, .wr_addr, .wr_data, .fetch_done
   );

   weight_buffer weight_buffer_inst (
      .clk, .wr_en, .wr_addr, .wr_data, .rd_en, .rd_addr, .rd_data
   );

   weight_stream weight_stream_inst (
      .clk, .rst, .fetch_done, .iter, .per, .start, .shift, .incr, .rd_data,
      .rd_en, .rd_addr, .weight_out, .weight_valid, .busy(stream_busy)
   );

endmodule

//--- tb/weight_read_properties.sv
module weight_read_properties
   import weight_read_pkg::*;
(
   input logic  clk,
   input logic  rst,
   input logic  wb_cyc,
   input logic  wb_stb,
   input logic  wb_ack,
   input addr_t wb_adr,
   input logic  done,
   input logic  weight_valid
);

   timeunit 1ns;
   timeprecision 1ps;

   int assert_fail_count = 0;

   // classic master, cyc and stb move together
   cyc_equals_stb: assert property (@(posedge clk) disable iff (rst) wb_cyc == wb_stb)
      else begin
         assert_fail_count++;
         $error("wb_cyc and wb_stb differ");
      end

   // address held until the slave acks
   adr_held: assert property (@(posedge clk) disable iff (rst)
      (wb_stb && !wb_ack) |=> $stable(wb_adr))
      else begin
         assert_fail_count++;
         $error("wb_adr changed while a transfer was waiting for ack");
      end

   valid_only_busy: assert property (@(posedge clk) disable iff (rst) !(weight_valid && done))
      else begin
         assert_fail_count++;
         $error("weight_valid high while done is high");
      end

endmodule

//--- tb/weight_read_checker.sv
module weight_read_checker
   import weight_read_pkg::*;
(
   input  logic      clk,
   input  logic      rst,
   input  logic      cfg_valid,
   input  logic      cfg_we,
   input  cfg_addr_t cfg_addr,
   input  data_t     cfg_wdata,
   input  logic      run,
   input  logic      wb_ack,
   input  data_t     wb_dat_i,
   input  logic      done,
   input  logic      wb_cyc,
   input  logic      wb_stb,
   input  addr_t     wb_adr,
   input  data_t     weight_out,
   input  logic      weight_valid,
   output int        mismatch_count,
   output int        other_count
);

   timeunit 1ns;
   timeprecision 1ps;

   // cpu side registers and the buffer as seen from the bus
   data_t work_reg [8];
   data_t model_buf [64];

   // job frozen on an accepted run
   addr_t sh_ext;
   int    sh_len;
   int    sh_int;
   int    sh_iter;
   int    sh_per;
   int    sh_start;
   int    sh_shift;
   int    sh_incr;

   logic  active = 1'b0;
   int    xfer_cnt = 0;
   int    weight_cnt = 0;
   int    mismatches = 0;
   int    failures = 0;

   assign mismatch_count = mismatches;
   assign other_count    = failures;

   task automatic note_mismatch(input string msg);
      mismatches++;
      $display("MISMATCH %0t: %s", $time, msg);
   endtask

   task automatic note_failure(input string msg);
      failures++;
      $display("ERROR %0t: %s", $time, msg);
   endtask

   // buffer address of weight number idx in the nested loop
   function automatic buf_addr_t expected_read_addr(input int idx);
      int it;
      int p;
      it = idx / sh_per;
      p  = idx % sh_per;
      return buf_addr_t'((sh_start + it * sh_shift + p * sh_incr) % 64);
   endfunction

   always @(posedge clk or posedge rst) begin
      buf_addr_t idx;
      addr_t     exp_adr;
      data_t     exp_w;
      if (rst) begin
         active     = 1'b0;
         xfer_cnt   = 0;
         weight_cnt = 0;
         for (int r = 0; r < 8; r++) begin
            work_reg[r] = '0;
         end
      end else begin
         // first edge that sees done high again closes the run
         if (active && done) begin
            if (xfer_cnt != sh_len) begin
               note_mismatch($sformatf("%0d transfers, expected %0d", xfer_cnt, sh_len));
            end
            if (weight_cnt != sh_iter * sh_per) begin
               note_mismatch($sformatf("%0d weights, expected %0d", weight_cnt,
                                       sh_iter * sh_per));
            end
            active = 1'b0;
         end
         if (!active) begin
            if (done !== 1'b1) begin
               note_failure("done is low with no run in progress");
            end
            if (wb_cyc !== 1'b0 || wb_stb !== 1'b0) begin
               note_failure("bus cycle with no run in progress");
            end
            if (weight_valid !== 1'b0) begin
               note_failure("weight_valid high with no run in progress");
            end
            if (run) begin
               sh_ext     = work_reg[CFG_EXT_ADDR][ADDR_W-1:0];
               sh_len     = int'(work_reg[CFG_LEN][CNT_W-1:0]);
               sh_int     = int'(work_reg[CFG_INT_ADDR][BUF_ADDR_W-1:0]);
               sh_iter    = int'(work_reg[CFG_ITER][CNT_W-1:0]);
               sh_per     = int'(work_reg[CFG_PER][CNT_W-1:0]);
               sh_start   = int'(work_reg[CFG_START][BUF_ADDR_W-1:0]);
               sh_shift   = int'(work_reg[CFG_SHIFT][BUF_ADDR_W-1:0]);
               sh_incr    = int'(work_reg[CFG_INCR][BUF_ADDR_W-1:0]);
               xfer_cnt   = 0;
               weight_cnt = 0;
               active     = 1'b1;
            end
         end
         if (active && wb_cyc) begin
            if (xfer_cnt >= sh_len) begin
               note_failure("bus cycle after the last transfer of the block");
            end else if (wb_ack) begin
               exp_adr = sh_ext + addr_t'(xfer_cnt);
               if (wb_adr !== exp_adr) begin
                  note_mismatch($sformatf("transfer %0d wb_adr %h, expected %h",
                                          xfer_cnt, wb_adr, exp_adr));
               end
               idx = buf_addr_t'((sh_int + xfer_cnt) % 64);
               model_buf[idx] = wb_dat_i;
               xfer_cnt++;
            end
         end
         if (active && weight_valid) begin
            if (weight_cnt >= sh_iter * sh_per) begin
               note_failure("more weights than iter times per");
            end else begin
               exp_w = model_buf[expected_read_addr(weight_cnt)];
               if (weight_out !== exp_w) begin
                  note_mismatch($sformatf("weight %0d is %h, expected %h",
                                          weight_cnt, weight_out, exp_w));
               end
               weight_cnt++;
            end
         end
         // the shadow copy above takes the value from before this edge
         if (cfg_valid && cfg_we) begin
            work_reg[cfg_addr] = cfg_wdata;
         end
      end
   end

endmodule

//--- tb/weight_read_tb.sv
module weight_read_tb
   import weight_read_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_ROWS     = 7;
   localparam int DONE_TIMEOUT = 2000;

   logic      clk;
   logic      rst       = 1'b1;
   logic      cfg_valid = 1'b0;
   logic      cfg_we    = 1'b0;
   cfg_addr_t cfg_addr  = '0;
   data_t     cfg_wdata = '0;
   logic      run       = 1'b0;
   logic      wb_ack    = 1'b0;
   data_t     wb_dat_i  = '0;
   logic      done;
   logic      wb_cyc;
   logic      wb_stb;
   addr_t     wb_adr;
   data_t     weight_out;
   logic      weight_valid;
   int        mismatch_count;
   int        other_count;
   int        assert_fails;
   integer    seed      = 32'h73f41471;
   int        ack_wait  = 0;
   logic      ack_armed = 1'b0;
   logic      timed_out = 1'b0;

   // columns: ext_addr, len, int_addr, iter, per, start, shift, incr
   data_t row_tab [NUM_ROWS][8] = '{
      '{32'h1000, 32'd64, 32'd5,  32'd4, 32'd8, 32'd0,  32'd8,  32'd1},
      '{32'hfff8, 32'd20, 32'd50, 32'd3, 32'd5, 32'd60, 32'd7,  32'd3},
      '{32'h0200, 32'd0,  32'd0,  32'd2, 32'd3, 32'd10, 32'd1,  32'd2},
      '{32'h0300, 32'd10, 32'd0,  32'd0, 32'd4, 32'd0,  32'd1,  32'd1},
      '{32'h0400, 32'd8,  32'd32, 32'd5, 32'd0, 32'd0,  32'd1,  32'd1},
      '{32'habcd, 32'd16, 32'd40, 32'd6, 32'd6, 32'd63, 32'd63, 32'd5},
      '{32'h0010, 32'd1,  32'd63, 32'd1, 32'd1, 32'd63, 32'd0,  32'd0}
   };

   weight_read_top weight_read_top_inst (
      .clk, .rst, .cfg_valid, .cfg_we, .cfg_addr, .cfg_wdata, .run, .wb_ack, .wb_dat_i,
      .done, .wb_cyc, .wb_stb, .wb_adr, .weight_out, .weight_valid
   );

   weight_read_checker weight_read_checker_inst (
      .clk, .rst, .cfg_valid, .cfg_we, .cfg_addr, .cfg_wdata, .run, .wb_ack, .wb_dat_i,
      .done, .wb_cyc, .wb_stb, .wb_adr, .weight_out, .weight_valid,
      .mismatch_count, .other_count
   );

   bind weight_read_top weight_read_properties weight_read_properties_inst (
      .clk(clk), .rst(rst), .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_ack(wb_ack),
      .wb_adr(wb_adr), .done(done), .weight_valid(weight_valid)
   );

   assign assert_fails = weight_read_top_inst.weight_read_properties_inst.assert_fail_count;

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // external memory, word {a, ~a} after 0 to 3 wait cycles
   always @(posedge clk) begin
      if (rst) begin
         wb_ack    <= 1'b0;
         ack_armed = 1'b0;
      end else if (wb_ack) begin
         wb_ack <= 1'b0;
      end else if (wb_stb) begin
         if (!ack_armed) begin
            ack_wait  = $random(seed) & 3;
            ack_armed = 1'b1;
         end
         if (ack_wait == 0) begin
            wb_ack    <= 1'b1;
            wb_dat_i  <= {wb_adr, ~wb_adr};
            ack_armed = 1'b0;
         end else begin
            ack_wait = ack_wait - 1;
         end
      end
   end

   task automatic write_reg(input cfg_addr_t addr, input data_t value);
      @(posedge clk);
      cfg_valid <= 1'b1;
      cfg_we    <= 1'b1;
      cfg_addr  <= addr;
      cfg_wdata <= value;
   endtask

   task automatic wait_for_done(output logic ok);
      int cycles;
      cycles = 0;
      @(posedge clk);
      while (!done && cycles < DONE_TIMEOUT) begin
         @(posedge clk);
         cycles++;
      end
      ok = done;
      if (!ok) begin
         $display("timeout: done did not return high within %0d cycles", DONE_TIMEOUT);
      end
   endtask

   task automatic run_row(input int row, output logic ok);
      for (int i = 0; i < 8; i++) begin
         write_reg(cfg_addr_t'(i), row_tab[row][i]);
      end
      @(posedge clk);
      cfg_valid <= 1'b0;
      cfg_we    <= 1'b0;
      run       <= 1'b1;
      @(posedge clk);
      run <= 1'b0;
      // second pulse lands while the fetch is still going
      if (row_tab[row][CFG_LEN] != '0) begin
         @(posedge clk);
         run <= 1'b1;
         @(posedge clk);
         run <= 1'b0;
      end
      // stage garbage for a job that never runs
      for (int i = 0; i < 8; i++) begin
         write_reg(cfg_addr_t'(i), data_t'($random(seed)));
      end
      @(posedge clk);
      cfg_valid <= 1'b0;
      cfg_we    <= 1'b0;
      wait_for_done(ok);
   endtask

   initial begin
      logic ok;
      repeat (2) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);
      for (int row = 0; row < NUM_ROWS; row++) begin
         run_row(row, ok);
         if (!ok) begin
            timed_out = 1'b1;
            break;
         end
      end
      repeat (4) @(posedge clk);
      $display("errors: %0d mismatches, %0d other, %0d assertion failures",
               mismatch_count, other_count, assert_fails);
      if (timed_out || mismatch_count != 0 || other_count != 0 || assert_fails != 0) begin
         $display("test failed");
      end else begin
         $display("test passed");
      end
      $finish;
   end

endmodule

//--- project.f
logic/weight_read_pkg.sv
logic/read_config.sv
logic/weight_fetch.sv
logic/weight_buffer.sv
logic/weight_stream.sv
logic/weight_read_top.sv
tb/weight_read_properties.sv
tb/weight_read_checker.sv
tb/weight_read_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= weight_read_tb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o $(TOP)
	@out="$$(./$(BUILD_DIR)/$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
